// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

  // Host command path widths
  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;
  localparam int RESP_W     = 40;
  localparam int SERIAL_W   = 8;
  localparam int SLOT_W     = 2;

  // Addresses decoded by the register block
  localparam logic [CMD_ADDR_W-1:0] ADDR_FREQ   = 6'h01;
  localparam logic [CMD_ADDR_W-1:0] ADDR_SERIAL = 6'h02;
  localparam logic [CMD_ADDR_W-1:0] ADDR_CFG    = 6'h09;

  // Bit positions inside ADDR_CFG data
  localparam int CFG_DATA_VNA    = 23;
  localparam int CFG_DATA_PA_EN  = 19;
  localparam int CFG_DATA_TR_DIS = 18;

  // Packed config bits, vna on top
  localparam int CFG_W      = 3;
  localparam int CFG_VNA    = 2;
  localparam int CFG_PA_EN  = 1;
  localparam int CFG_TR_DIS = 0;

  // One queued command echo
  typedef struct packed {
    logic [CMD_ADDR_W-1:0] addr;
    logic [CMD_DATA_W-1:0] data;
  } resp_entry_t;

  // Response word carrying a command echo
  typedef struct packed {
    logic                  echo;
    logic [CMD_ADDR_W-1:0] addr;
    logic                  tx_on;
    logic [CMD_DATA_W-1:0] data;
  } resp_echo_t;

  // Response word carrying a telemetry slot
  typedef struct packed {
    logic                  echo;
    logic [1:0]            rsvd_hi;
    logic [SLOT_W-1:0]     slot;
    logic                  tx_on;
    logic                  clip;
    logic                  rsvd_lo;
    logic [CMD_DATA_W-1:0] payload;
  } resp_telem_t;

endpackage

// ==== logic/tick_gen.sv ====
module tick_gen #(
  parameter int MS_DIV      = 2500,
  parameter int LED_TICK_MS = 64
) (
  input  logic clk,
  input  logic reset_i,
  output logic ms_pulse_o,
  output logic led_tick_o
);

  localparam int MS_W  = (MS_DIV > 1) ? $clog2(MS_DIV) : 1;
  localparam int LED_W = (LED_TICK_MS > 1) ? $clog2(LED_TICK_MS) : 1;

  logic [MS_W-1:0]  ms_cnt;
  logic [LED_W-1:0] led_cnt;
  logic             ms_wrap;
  logic             led_wrap;

  assign ms_wrap  = (ms_cnt == MS_W'(MS_DIV - 1));
  assign led_wrap = (led_cnt == LED_W'(LED_TICK_MS - 1));

  // Both pulses are registered so they line up on the same cycle
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ms_cnt     <= '0;
      led_cnt    <= '0;
      ms_pulse_o <= 1'b0;
      led_tick_o <= 1'b0;
    end else begin
      ms_cnt     <= ms_wrap ? '0 : ms_cnt + 1'b1;
      ms_pulse_o <= ms_wrap;
      led_tick_o <= ms_wrap & led_wrap;
      // LED counter steps once per millisecond
      if (ms_wrap) begin
        led_cnt <= led_wrap ? '0 : led_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== logic/led_flash.sv ====
module led_flash (
  input  logic clk,
  input  logic reset_i,
  input  logic tick_i,
  input  logic event_i,
  output logic led_o
);

  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,
    ST_SET   = 2'b01,
    ST_WAIT1 = 2'b10,
    ST_WAIT2 = 2'b11
  } flash_state_t;

  flash_state_t state;
  flash_state_t state_next;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Armed by an event, then three ticks before going dark again
  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (event_i) begin
          state_next = ST_SET;
        end
      end
      ST_SET: begin
        if (tick_i) begin
          state_next = ST_WAIT1;
        end
      end
      ST_WAIT1: begin
        if (tick_i) begin
          state_next = ST_WAIT2;
        end
      end
      default: begin
        if (tick_i) begin
          state_next = ST_IDLE;
        end
      end
    endcase
  end

  // Active low, LED dark only while idle
  assign led_o = (state == ST_IDLE);

endmodule

// ==== logic/cmd_regs.sv ====
module cmd_regs #(
  parameter int RESP_DEPTH = 4
) (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic [ctrl_pkg::CMD_ADDR_W-1:0]  cmd_addr_i,
  input  logic [ctrl_pkg::CMD_DATA_W-1:0]  cmd_data_i,
  input  logic                             cmd_rqst_i,
  input  logic                             cmd_resp_i,
  input  logic                             cmd_ptt_i,
  input  logic                             ptt_i,
  input  logic                             txinhibit_i,
  input  logic                             run_i,
  input  logic                             credit_i,
  output logic                             push_o,
  output ctrl_pkg::resp_entry_t            entry_o,
  output logic [ctrl_pkg::CFG_W-1:0]       cfg_o,
  output logic [ctrl_pkg::CMD_DATA_W-1:0]  tx_freq_o,
  output logic [ctrl_pkg::SERIAL_W-1:0]    serial_o,
  output logic                             tx_on_o,
  output logic                             pa_tr_o,
  output logic                             pa_en_o,
  output logic                             rfsw_sel_o
);

  import ctrl_pkg::*;

  localparam int CRED_W = $clog2(RESP_DEPTH + 1);

  logic                  int_ptt;
  logic                  ptt_next;
  logic                  tx_on_q;
  logic [CFG_W-1:0]      cfg_q;
  logic [CMD_DATA_W-1:0] tx_freq_q;
  logic [SERIAL_W-1:0]   serial_q;
  logic [CRED_W-1:0]     credits;
  logic                  resp_accept;

  // Every command carries a fresh PTT bit
  assign ptt_next    = cmd_rqst_i ? cmd_ptt_i : int_ptt;
  assign resp_accept = cmd_rqst_i & cmd_resp_i & (credits != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      int_ptt   <= 1'b0;
      tx_on_q   <= 1'b0;
      cfg_q     <= '0;
      tx_freq_q <= '0;
      serial_q  <= '0;
    end else begin
      int_ptt <= ptt_next;
      // Registered so it moves together with the config bits
      tx_on_q <= (ptt_next | ptt_i) & ~txinhibit_i & run_i;
      if (cmd_rqst_i) begin
        case (cmd_addr_i)
          ADDR_CFG: begin
            cfg_q[CFG_VNA]    <= cmd_data_i[CFG_DATA_VNA];
            cfg_q[CFG_PA_EN]  <= cmd_data_i[CFG_DATA_PA_EN];
            cfg_q[CFG_TR_DIS] <= cmd_data_i[CFG_DATA_TR_DIS];
          end
          ADDR_FREQ:   tx_freq_q <= cmd_data_i;
          ADDR_SERIAL: serial_q  <= cmd_data_i[SERIAL_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Credit count, push spends one and a returned credit adds one
  always_ff @(posedge clk) begin
    if (reset_i) begin
      push_o  <= 1'b0;
      credits <= CRED_W'(RESP_DEPTH);
    end else begin
      push_o  <= resp_accept;
      credits <= credits - CRED_W'(resp_accept) + CRED_W'(credit_i);
    end
  end

  always_ff @(posedge clk) begin
    if (resp_accept) begin
      entry_o.addr <= cmd_addr_i;
      entry_o.data <= cmd_data_i;
    end
  end

  assign tx_on_o    = tx_on_q;
  assign pa_tr_o    = tx_on_q & ~cfg_q[CFG_VNA] & (cfg_q[CFG_PA_EN] | ~cfg_q[CFG_TR_DIS]);
  assign pa_en_o    = tx_on_q & ~cfg_q[CFG_VNA] & cfg_q[CFG_PA_EN];
  assign rfsw_sel_o = ~cfg_q[CFG_VNA] & cfg_q[CFG_PA_EN];
  assign cfg_o      = cfg_q;
  assign tx_freq_o  = tx_freq_q;
  assign serial_o   = serial_q;

endmodule

// ==== logic/resp_fifo.sv ====
module resp_fifo #(
  parameter int RESP_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  push_i,
  input  ctrl_pkg::resp_entry_t entry_i,
  input  logic                  pop_i,
  output logic                  head_valid_o,
  output ctrl_pkg::resp_entry_t head_o,
  output logic                  credit_o
);

  import ctrl_pkg::*;

  localparam int PTR_W = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
  localparam int CNT_W = $clog2(RESP_DEPTH + 1);

  resp_entry_t       mem [RESP_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_pop;
  logic              wr_last;
  logic              rd_last;

  assign do_pop  = pop_i & head_valid_o;
  assign wr_last = (wr_ptr == PTR_W'(RESP_DEPTH - 1));
  assign rd_last = (rd_ptr == PTR_W'(RESP_DEPTH - 1));

  // Producer never pushes without a credit, so no overflow check here
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_last ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_last ? '0 : rd_ptr + 1'b1;
      end
      count    <= count + CNT_W'(push_i) - CNT_W'(do_pop);
      // Credit goes back one cycle after the entry leaves
      credit_o <= do_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= entry_i;
    end
  end

  assign head_valid_o = (count != '0);
  assign head_o       = mem[rd_ptr];

endmodule

// ==== logic/resp_builder.sv ====
module resp_builder (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             resp_rqst_i,
  input  logic                             head_valid_i,
  input  ctrl_pkg::resp_entry_t            head_i,
  output logic                             pop_o,
  input  logic                             tx_on_i,
  input  logic                             rxclip_i,
  input  logic [ctrl_pkg::CFG_W-1:0]       cfg_i,
  input  logic [ctrl_pkg::CMD_DATA_W-1:0]  tx_freq_i,
  input  logic [ctrl_pkg::SERIAL_W-1:0]    serial_i,
  output logic [ctrl_pkg::RESP_W-1:0]      resp_o
);

  import ctrl_pkg::*;

  logic [SLOT_W-1:0] slot_q;
  logic              clip_q;
  logic [RESP_W-1:0] resp_q;
  resp_echo_t        echo_word;
  resp_telem_t       telem_word;

  // Head is consumed in the same cycle as the request
  assign pop_o = resp_rqst_i & head_valid_i;

  always_comb begin
    echo_word.echo  = 1'b1;
    echo_word.addr  = head_i.addr;
    echo_word.tx_on = tx_on_i;
    echo_word.data  = head_i.data;
  end

  always_comb begin
    telem_word       = '0;
    telem_word.slot  = slot_q;
    telem_word.tx_on = tx_on_i;
    telem_word.clip  = clip_q;
    case (slot_q)
      2'd0: begin
        telem_word.payload = CMD_DATA_W'(serial_i);
      end
      2'd1: begin
        telem_word.payload = tx_freq_i;
      end
      2'd2: begin
        telem_word.payload = CMD_DATA_W'(cfg_i);
      end
      default: begin
        telem_word.payload = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      slot_q <= '0;
      clip_q <= 1'b0;
      resp_q <= '0;
    end else begin
      if (resp_rqst_i) begin
        // Slot still steps when an echo takes the response
        slot_q <= slot_q + 1'b1;
        clip_q <= 1'b0;
        if (head_valid_i) begin
          resp_q <= echo_word;
        end else begin
          resp_q <= telem_word;
        end
      end else if (rxclip_i) begin
        // Sticky until the host reads it
        clip_q <= 1'b1;
      end
    end
  end

  assign resp_o = resp_q;

endmodule

// ==== logic/radio_ctrl.sv ====
module radio_ctrl #(
  parameter int MS_DIV      = 2500,
  parameter int LED_TICK_MS = 64,
  parameter int RESP_DEPTH  = 4
) (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic [ctrl_pkg::CMD_ADDR_W-1:0]  cmd_addr_i,
  input  logic [ctrl_pkg::CMD_DATA_W-1:0]  cmd_data_i,
  input  logic                             cmd_rqst_i,
  input  logic                             cmd_resp_i,
  input  logic                             cmd_ptt_i,
  input  logic                             ptt_i,
  input  logic                             txinhibit_i,
  input  logic                             run_i,
  input  logic                             rxclip_i,
  input  logic                             rxgoodlvl_i,
  input  logic                             resp_rqst_i,
  output logic [ctrl_pkg::RESP_W-1:0]      resp_o,
  output logic                             tx_on_o,
  output logic                             pa_tr_o,
  output logic                             pa_en_o,
  output logic                             rfsw_sel_o,
  output logic                             led_clip_o,
  output logic                             led_good_o
);

  import ctrl_pkg::*;

  logic                  led_tick;
  logic                  push;
  resp_entry_t           entry;
  logic                  credit;
  logic                  pop;
  logic                  head_valid;
  resp_entry_t           head;
  logic [CFG_W-1:0]      cfg;
  logic [CMD_DATA_W-1:0] tx_freq;
  logic [SERIAL_W-1:0]   serial;

  // Millisecond pulse only feeds the LED tick inside tick_gen
  tick_gen #(
    .MS_DIV      (MS_DIV),
    .LED_TICK_MS (LED_TICK_MS)
  ) i_tick_gen (
    .clk        (clk),
    .reset_i    (reset_i),
    .ms_pulse_o (),
    .led_tick_o (led_tick)
  );

  led_flash i_led_clip (
    .clk     (clk),
    .reset_i (reset_i),
    .tick_i  (led_tick),
    .event_i (rxclip_i),
    .led_o   (led_clip_o)
  );

  led_flash i_led_good (
    .clk     (clk),
    .reset_i (reset_i),
    .tick_i  (led_tick),
    .event_i (rxgoodlvl_i),
    .led_o   (led_good_o)
  );

  cmd_regs #(
    .RESP_DEPTH (RESP_DEPTH)
  ) i_cmd_regs (
    .clk         (clk),
    .reset_i     (reset_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_rqst_i  (cmd_rqst_i),
    .cmd_resp_i  (cmd_resp_i),
    .cmd_ptt_i   (cmd_ptt_i),
    .ptt_i       (ptt_i),
    .txinhibit_i (txinhibit_i),
    .run_i       (run_i),
    .credit_i    (credit),
    .push_o      (push),
    .entry_o     (entry),
    .cfg_o       (cfg),
    .tx_freq_o   (tx_freq),
    .serial_o    (serial),
    .tx_on_o     (tx_on_o),
    .pa_tr_o     (pa_tr_o),
    .pa_en_o     (pa_en_o),
    .rfsw_sel_o  (rfsw_sel_o)
  );

  resp_fifo #(
    .RESP_DEPTH (RESP_DEPTH)
  ) i_resp_fifo (
    .clk          (clk),
    .reset_i      (reset_i),
    .push_i       (push),
    .entry_i      (entry),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_o       (head),
    .credit_o     (credit)
  );

  resp_builder i_resp_builder (
    .clk          (clk),
    .reset_i      (reset_i),
    .resp_rqst_i  (resp_rqst_i),
    .head_valid_i (head_valid),
    .head_i       (head),
    .pop_o        (pop),
    .tx_on_i      (tx_on_o),
    .rxclip_i     (rxclip_i),
    .cfg_i        (cfg),
    .tx_freq_i    (tx_freq),
    .serial_i     (serial),
    .resp_o       (resp_o)
  );

endmodule

// ==== tb/tb_checker.sv ====
module tb_checker #(
  parameter int MS_DIV      = 4,
  parameter int LED_TICK_MS = 2,
  parameter int RESP_DEPTH  = 4
) (
  input  logic                            clk,
  input  logic                            reset_i,
  input  logic [ctrl_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [ctrl_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                            cmd_rqst_i,
  input  logic                            cmd_resp_i,
  input  logic                            cmd_ptt_i,
  input  logic                            ptt_i,
  input  logic                            txinhibit_i,
  input  logic                            run_i,
  input  logic                            rxclip_i,
  input  logic                            rxgoodlvl_i,
  input  logic                            resp_rqst_i,
  input  logic [ctrl_pkg::RESP_W-1:0]     resp_i,
  input  logic                            tx_on_i,
  input  logic                            pa_tr_i,
  input  logic                            pa_en_i,
  input  logic                            rfsw_sel_i,
  input  logic                            led_clip_i,
  input  logic                            led_good_i,
  input  int                              test_id_i,
  output int                              errors_o,
  output int                              checks_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import ctrl_pkg::*;

  localparam int TICK_CYC = MS_DIV * LED_TICK_MS;

  // Model of the DUT state after the latest clock edge
  logic                  m_int_ptt;
  logic                  m_tx_on;
  logic                  m_vna;
  logic                  m_pa_en;
  logic                  m_tr_dis;
  logic [CMD_DATA_W-1:0] m_freq;
  logic [7:0]            m_serial;
  int                    m_credits;
  logic                  m_push;
  logic [37:0]           m_entry;
  logic                  m_credit;
  logic [37:0]           m_echoes[$];
  logic [1:0]            m_slot;
  logic                  m_clip;
  logic [RESP_W-1:0]     m_resp;
  logic                  m_lit[2];
  int                    m_ticks[2];
  int                    led_cyc = 0;
  bit                    model_valid = 1'b0;
  int                    cur_id = 0;
  int                    test_checks = 0;
  int                    test_errors = 0;
  int                    total_checks = 0;
  int                    total_errors = 0;

  assign errors_o = total_errors;
  assign checks_o = total_checks;

  function automatic string test_name(input int id);
    case (id)
      1: return "reset";
      2: return "cfg_outputs";
      3: return "telemetry";
      4: return "echo_order";
      5: return "credit_burst";
      6: return "led_flash";
      default: return "none";
    endcase
  endfunction

  task automatic report_test();
    $display("test %-12s checks=%0d errors=%0d %s", test_name(cur_id), test_checks,
             test_errors, (test_errors == 0) ? "ok" : "failed");
  endtask

  task automatic count_error();
    test_errors++;
    total_errors++;
  endtask

  task automatic compare(input string sig, input logic [RESP_W-1:0] exp_val,
                         input logic [RESP_W-1:0] act_val);
    test_checks++;
    total_checks++;
    if (act_val !== exp_val) begin
      count_error();
      $display("CHECK FAILED test=%s signal=%s expected=%0h actual=%0h",
               test_name(cur_id), sig, exp_val, act_val);
    end
  endtask

  function automatic logic [CMD_DATA_W-1:0] telem_payload();
    case (m_slot)
      2'd0: return {24'h0, m_serial};
      2'd1: return m_freq;
      2'd2: return {29'h0, m_vna, m_pa_en, m_tr_dis};
      default: return '0;
    endcase
  endfunction

  task automatic reset_model();
    m_int_ptt = 1'b0;
    m_tx_on   = 1'b0;
    m_vna     = 1'b0;
    m_pa_en   = 1'b0;
    m_tr_dis  = 1'b0;
    m_freq    = '0;
    m_serial  = '0;
    m_credits = RESP_DEPTH;
    m_push    = 1'b0;
    m_credit  = 1'b0;
    m_slot    = '0;
    m_clip    = 1'b0;
    m_resp    = '0;
    led_cyc   = 0;
    m_echoes.delete();
    for (int i = 0; i < 2; i++) begin
      m_lit[i]   = 1'b0;
      m_ticks[i] = 0;
    end
  endtask

  // Lit from the cycle after the event until three ticks have passed
  task automatic step_led(input int idx, input logic ev, input bit tick);
    if (m_lit[idx]) begin
      if (tick) begin
        m_ticks[idx]++;
      end
      if (m_ticks[idx] == 3) begin
        m_lit[idx] = 1'b0;
      end
    end else if (ev) begin
      m_lit[idx]   = 1'b1;
      m_ticks[idx] = 0;
    end
  endtask

  // Advance the model across one edge using the inputs sampled now
  task automatic step_model();
    logic        ptt_next;
    logic        accept;
    logic [37:0] head;
    bit          tick;
    ptt_next  = cmd_rqst_i ? cmd_ptt_i : m_int_ptt;
    accept    = cmd_rqst_i & cmd_resp_i & (m_credits > 0);
    m_credits = m_credits - int'(accept) + int'(m_credit);
    m_credit  = 1'b0;
    if (resp_rqst_i) begin
      if (m_echoes.size() > 0) begin
        head     = m_echoes.pop_front();
        m_resp   = {1'b1, head[37:32], m_tx_on, head[31:0]};
        m_credit = 1'b1;
      end else begin
        m_resp = {1'b0, 2'b00, m_slot, m_tx_on, m_clip, 1'b0, telem_payload()};
      end
      m_slot = m_slot + 2'd1;
      m_clip = 1'b0;
    end else if (rxclip_i) begin
      m_clip = 1'b1;
    end
    // An entry pushed last cycle joins behind any entry popped now
    if (m_push) begin
      m_echoes.push_back(m_entry);
    end
    m_push = accept;
    if (accept) begin
      m_entry = {cmd_addr_i, cmd_data_i};
    end
    m_tx_on   = (ptt_next | ptt_i) & ~txinhibit_i & run_i;
    m_int_ptt = ptt_next;
    if (cmd_rqst_i) begin
      case (cmd_addr_i)
        ADDR_CFG: begin
          m_vna    = cmd_data_i[23];
          m_pa_en  = cmd_data_i[19];
          m_tr_dis = cmd_data_i[18];
        end
        ADDR_FREQ:   m_freq   = cmd_data_i;
        ADDR_SERIAL: m_serial = cmd_data_i[7:0];
        default: ;
      endcase
    end
    // LED tick falls every TICK_CYC cycles counted from reset
    tick = (led_cyc != 0) && (led_cyc % TICK_CYC == 0);
    led_cyc++;
    step_led(0, rxclip_i, tick);
    step_led(1, rxgoodlvl_i, tick);
  endtask

  // LED outputs are low while lit
  task automatic check_outputs();
    compare("tx_on_o", RESP_W'(m_tx_on), RESP_W'(tx_on_i));
    compare("pa_tr_o", RESP_W'(m_tx_on & ~m_vna & (m_pa_en | ~m_tr_dis)), RESP_W'(pa_tr_i));
    compare("pa_en_o", RESP_W'(m_tx_on & ~m_vna & m_pa_en), RESP_W'(pa_en_i));
    compare("rfsw_sel_o", RESP_W'(~m_vna & m_pa_en), RESP_W'(rfsw_sel_i));
    compare("resp_o", m_resp, resp_i);
    compare("led_clip_o", RESP_W'(!m_lit[0]), RESP_W'(led_clip_i));
    compare("led_good_o", RESP_W'(!m_lit[1]), RESP_W'(led_good_i));
  endtask

  // Inputs and outputs are both settled at the falling edge
  always @(negedge clk) begin
    if (test_id_i != cur_id) begin
      if (cur_id != 0) begin
        report_test();
      end
      cur_id      = test_id_i;
      test_checks = 0;
      test_errors = 0;
    end
    if (model_valid) begin
      check_outputs();
    end
    if (reset_i) begin
      reset_model();
      model_valid = 1'b1;
    end else if (model_valid) begin
      step_model();
    end
  end

endmodule

// ==== tb/tb_radio_ctrl.sv ====
module tb_radio_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  import ctrl_pkg::*;

  localparam int MS_DIV      = 4;
  localparam int LED_TICK_MS = 2;
  localparam int RESP_DEPTH  = 4;
  // Longest flash is three ticks, plus margin
  localparam int LED_LIMIT   = 4 * MS_DIV * LED_TICK_MS + 10;

  logic                  clk;
  logic                  reset_i;
  logic [CMD_ADDR_W-1:0] cmd_addr_i;
  logic [CMD_DATA_W-1:0] cmd_data_i;
  logic                  cmd_rqst_i;
  logic                  cmd_resp_i;
  logic                  cmd_ptt_i;
  logic                  ptt_i;
  logic                  txinhibit_i;
  logic                  run_i;
  logic                  rxclip_i;
  logic                  rxgoodlvl_i;
  logic                  resp_rqst_i;
  logic [RESP_W-1:0]     resp_o;
  logic                  tx_on_o;
  logic                  pa_tr_o;
  logic                  pa_en_o;
  logic                  rfsw_sel_o;
  logic                  led_clip_o;
  logic                  led_good_o;
  int                    test_id;
  int                    errors;
  int                    checks;
  int unsigned           seed_ret;

  radio_ctrl #(
    .MS_DIV      (MS_DIV),
    .LED_TICK_MS (LED_TICK_MS),
    .RESP_DEPTH  (RESP_DEPTH)
  ) i_dut (
    .clk (clk), .reset_i (reset_i), .cmd_addr_i (cmd_addr_i), .cmd_data_i (cmd_data_i),
    .cmd_rqst_i (cmd_rqst_i), .cmd_resp_i (cmd_resp_i), .cmd_ptt_i (cmd_ptt_i),
    .ptt_i (ptt_i), .txinhibit_i (txinhibit_i), .run_i (run_i), .rxclip_i (rxclip_i),
    .rxgoodlvl_i (rxgoodlvl_i), .resp_rqst_i (resp_rqst_i), .resp_o (resp_o),
    .tx_on_o (tx_on_o), .pa_tr_o (pa_tr_o), .pa_en_o (pa_en_o), .rfsw_sel_o (rfsw_sel_o),
    .led_clip_o (led_clip_o), .led_good_o (led_good_o)
  );

  tb_checker #(
    .MS_DIV      (MS_DIV),
    .LED_TICK_MS (LED_TICK_MS),
    .RESP_DEPTH  (RESP_DEPTH)
  ) i_checker (
    .clk (clk), .reset_i (reset_i), .cmd_addr_i (cmd_addr_i), .cmd_data_i (cmd_data_i),
    .cmd_rqst_i (cmd_rqst_i), .cmd_resp_i (cmd_resp_i), .cmd_ptt_i (cmd_ptt_i),
    .ptt_i (ptt_i), .txinhibit_i (txinhibit_i), .run_i (run_i), .rxclip_i (rxclip_i),
    .rxgoodlvl_i (rxgoodlvl_i), .resp_rqst_i (resp_rqst_i), .resp_i (resp_o),
    .tx_on_i (tx_on_o), .pa_tr_i (pa_tr_o), .pa_en_i (pa_en_o), .rfsw_sel_i (rfsw_sel_o),
    .led_clip_i (led_clip_o), .led_good_i (led_good_o), .test_id_i (test_id),
    .errors_o (errors), .checks_o (checks)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic chance(input int pct);
    return (($urandom % 100) < pct);
  endfunction

  function automatic logic [CMD_ADDR_W-1:0] pick_addr();
    case ($urandom % 4)
      0: return ADDR_CFG;
      1: return ADDR_FREQ;
      2: return ADDR_SERIAL;
      default: return CMD_ADDR_W'($urandom);
    endcase
  endfunction

  function automatic logic led_value(input logic good);
    return good ? led_good_o : led_clip_o;
  endfunction

  task automatic timeout(input string what);
    $display("Timeout: gave up waiting for %s", what);
    $display("STATUS: FAIL");
    $finish;
  endtask

  // One cycle of random inputs, the arguments are percentages
  task automatic drive_cycle(input int cmd_pct, input int resp_pct, input int rqst_pct,
                             input int clip_pct);
    @(posedge clk);
    cmd_rqst_i  <= chance(cmd_pct);
    cmd_resp_i  <= chance(resp_pct);
    cmd_addr_i  <= pick_addr();
    cmd_data_i  <= $urandom;
    cmd_ptt_i   <= chance(30);
    ptt_i       <= chance(10);
    txinhibit_i <= chance(10);
    run_i       <= chance(90);
    resp_rqst_i <= chance(rqst_pct);
    rxclip_i    <= chance(clip_pct);
    rxgoodlvl_i <= chance(clip_pct);
  endtask

  task automatic run_phase(input int cycles, input int cmd_pct, input int resp_pct,
                           input int rqst_pct, input int clip_pct);
    repeat (cycles) begin
      drive_cycle(cmd_pct, resp_pct, rqst_pct, clip_pct);
    end
  endtask

  task automatic spaced_requests(input int count);
    repeat (count) begin
      drive_cycle(0, 0, 100, 0);
      drive_cycle(0, 0, 0, 0);
    end
  endtask

  task automatic credit_burst();
    // Empty the queue left by the echo phase and let credits return
    spaced_requests(2 * RESP_DEPTH);
    run_phase(4, 0, 0, 0, 0);
    run_phase(RESP_DEPTH + 2, 100, 100, 0, 0);
    run_phase(4, 0, 0, 0, 0);
    spaced_requests(RESP_DEPTH + 4);
  endtask

  task automatic wait_led(input logic good, input logic level, input int limit,
                          input string what);
    int n;
    n = 0;
    while (led_value(good) !== level && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (led_value(good) !== level) begin
      timeout(what);
    end
  endtask

  task automatic led_pulse(input logic good);
    wait_led(good, 1'b1, LED_LIMIT, "LED to go dark before its pulse");
    drive_cycle(0, 0, 0, 0);
    if (good) begin
      rxgoodlvl_i <= 1'b1;
    end else begin
      rxclip_i <= 1'b1;
    end
    drive_cycle(0, 0, 0, 0);
    wait_led(good, 1'b0, 4, "LED to light after its pulse");
    wait_led(good, 1'b1, LED_LIMIT, "LED to go dark after its flash");
  endtask

  initial begin
    seed_ret    = $urandom(34732);
    reset_i     = 1'b1;
    cmd_addr_i  = '0;
    cmd_data_i  = '0;
    cmd_rqst_i  = 1'b0;
    cmd_resp_i  = 1'b0;
    cmd_ptt_i   = 1'b0;
    ptt_i       = 1'b0;
    txinhibit_i = 1'b0;
    run_i       = 1'b0;
    rxclip_i    = 1'b0;
    rxgoodlvl_i = 1'b0;
    resp_rqst_i = 1'b0;
    test_id     = 1;
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;
    run_phase(5, 0, 0, 0, 0);
    test_id <= 2;
    run_phase(200, 50, 0, 0, 0);
    test_id <= 3;
    run_phase(200, 30, 0, 40, 5);
    test_id <= 4;
    run_phase(300, 40, 50, 30, 5);
    test_id <= 5;
    credit_burst();
    test_id <= 6;
    led_pulse(1'b0);
    led_pulse(1'b1);
    test_id <= 7;
    repeat (2) @(posedge clk);
    $display("summary: tests=6 checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/ctrl_pkg.sv
logic/tick_gen.sv
logic/led_flash.sv
logic/cmd_regs.sv
logic/resp_fifo.sv
logic/resp_builder.sv
logic/radio_ctrl.sv
tb/tb_checker.sv
tb/tb_radio_ctrl.sv

// ==== Bender.yml ====
package:
  name: radio_ctrl

sources:
  - logic/ctrl_pkg.sv
  - logic/tick_gen.sv
  - logic/led_flash.sv
  - logic/cmd_regs.sv
  - logic/resp_fifo.sv
  - logic/resp_builder.sv
  - logic/radio_ctrl.sv
  - target: test
    files:
      - tb/tb_checker.sv
      - tb/tb_radio_ctrl.sv
